//--- logic/i2c_sram_pkg.sv
`default_nettype none

package i2c_sram_pkg;

	localparam int DATA_W = 16; // memory word
	localparam int BYTE_W = 8;  // one byte on the bus

	typedef logic [6:0]        dev_addr_t;
	typedef logic [DATA_W-1:0] mem_word_t;

	// value of the mode bit that follows the device address
	typedef enum logic {
		MODE_WRITE = 1'b0,
		MODE_READ  = 1'b1
	} rw_mode_e;

	typedef enum logic [3:0] {
		IDLE,
		GET_DEV_ADDR,
		GET_MODE,
		ADDR_ACK,
		GET_MEM_ADDR,
		MEM_ADDR_ACK,
		GET_DATA_HI,
		DATA_HI_ACK,
		GET_DATA_LO,
		DATA_LO_ACK,
		SEND_HI,
		HI_GET_ACK,
		SEND_LO,
		LO_GET_ACK,
		IGNORE
	} target_state_e;

	// one access to the shared sram
	typedef struct packed {
		logic      we;
		logic [7:0] addr;  // sram takes the low ADDR_W bits
		mem_word_t wdata;
	} mem_req_t;

	// pulses are one scl cycle wide
	typedef struct packed {
		logic scl_rise;
		logic scl_fall;
		logic start;
		logic stop;
		logic sda; // synchronized level
	} bus_event_t;

endpackage

`default_nettype wire

//--- logic/i2c_line_sync.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_line_sync
	import i2c_sram_pkg::*;
(
	input  logic       scl,
	input  logic       rst_n,
	input  logic       bus_scl,
	input  logic       bus_sda,
	output bus_event_t evt
);

	logic scl_s1, scl_s2, scl_q;
	logic sda_s1, sda_s2, sda_q;

	always_ff @(posedge scl) begin
		if (!rst_n) begin
			// idle bus is high on both lines
			scl_s1 <= 1'b1;
			scl_s2 <= 1'b1;
			scl_q  <= 1'b1;
			sda_s1 <= 1'b1;
			sda_s2 <= 1'b1;
			sda_q  <= 1'b1;
			evt    <= '{scl_rise: 1'b0, scl_fall: 1'b0, start: 1'b0, stop: 1'b0, sda: 1'b1};
		end else begin
			scl_s1 <= bus_scl;
			scl_s2 <= scl_s1;
			scl_q  <= scl_s2; // previous value for edge detect
			sda_s1 <= bus_sda;
			sda_s2 <= sda_s1;
			sda_q  <= sda_s2;

			evt.scl_rise <= scl_s2 & ~scl_q;
			evt.scl_fall <= ~scl_s2 & scl_q;
			// sda may only move while scl is low, except for start and stop
			evt.start    <= scl_s2 & scl_q & sda_q & ~sda_s2;
			evt.stop     <= scl_s2 & scl_q & ~sda_q & sda_s2;
			evt.sda      <= sda_s2;
		end
	end

endmodule

`default_nettype wire

//--- logic/i2c_target_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_target_fsm
	import i2c_sram_pkg::*;
(
	input  logic       scl,
	input  logic       rst_n,
	input  bus_event_t evt,
	input  dev_addr_t  dev_addr,
	output logic       sda_drive_low,
	output mem_req_t   req,
	output logic       req_valid,
	input  logic       gnt,
	input  mem_word_t  rdata,
	input  logic       rvalid
);

	target_state_e     state;
	rw_mode_e          mode;
	logic [3:0]        bit_cnt;    // rising edges seen in the current byte
	logic [BYTE_W-1:0] shreg;      // bits from the master, msb first
	logic [BYTE_W-1:0] hi_byte;
	mem_word_t         tx;         // word being sent, msb on the line
	logic [7:0]        ptr;        // memory address pointer
	logic              master_ack;
	logic              rx_state;
	logic              tx_state;

	assign rx_state = (state == GET_DEV_ADDR) || (state == GET_MODE) ||
		(state == GET_MEM_ADDR) || (state == GET_DATA_HI) || (state == GET_DATA_LO);
	assign tx_state = (state == SEND_HI) || (state == SEND_LO);

	always_ff @(posedge scl) begin
		if (!rst_n) begin
			state         <= IDLE;
			mode          <= MODE_WRITE;
			bit_cnt       <= '0;
			shreg         <= '0;
			hi_byte       <= '0;
			tx            <= '0;
			ptr           <= '0;
			master_ack    <= 1'b0;
			sda_drive_low <= 1'b0;
			req           <= '0;
			req_valid     <= 1'b0;
		end else begin
			// target has priority, so a request is granted at once
			if (gnt) begin
				req_valid <= 1'b0;
				if (req.we)
					ptr <= ptr + 8'd1; // next word of a write burst
			end

			// first bit of a read word goes out once the data is back
			if (rvalid && state == SEND_HI) begin
				tx            <= rdata;
				sda_drive_low <= ~rdata[DATA_W-1];
			end

			if (evt.start) begin // repeated start behaves the same
				state         <= GET_DEV_ADDR;
				bit_cnt       <= '0;
				sda_drive_low <= 1'b0;
			end else if (evt.stop) begin
				state         <= IDLE;
				bit_cnt       <= '0;
				sda_drive_low <= 1'b0;
			end else if (evt.scl_rise) begin
				if (rx_state)
					shreg <= {shreg[BYTE_W-2:0], evt.sda};
				if (rx_state || tx_state)
					bit_cnt <= bit_cnt + 4'd1;
				if (state == HI_GET_ACK || state == LO_GET_ACK)
					master_ack <= ~evt.sda; // low sda is an ack
			end else if (evt.scl_fall) begin
				case (state)
					GET_DEV_ADDR: begin
						if (bit_cnt == 4'd7)
							state <= GET_MODE;
					end
					GET_MODE: begin
						if (bit_cnt == 4'd8) begin
							mode <= rw_mode_e'(shreg[0]);
							if (shreg[7:1] == dev_addr) begin
								state         <= ADDR_ACK;
								sda_drive_low <= 1'b1;
							end else begin
								state <= IGNORE; // not us, stay off the bus
							end
						end
					end
					ADDR_ACK: begin
						sda_drive_low <= 1'b0;
						bit_cnt       <= '0;
						if (mode == MODE_WRITE) begin
							state <= GET_MEM_ADDR;
						end else begin
							state     <= SEND_HI;
							req       <= '{we: 1'b0, addr: ptr, wdata: '0};
							req_valid <= 1'b1;
						end
					end
					GET_MEM_ADDR: begin
						if (bit_cnt == 4'd8) begin
							ptr           <= shreg;
							sda_drive_low <= 1'b1;
							state         <= MEM_ADDR_ACK;
						end
					end
					MEM_ADDR_ACK: begin
						sda_drive_low <= 1'b0;
						bit_cnt       <= '0;
						state         <= GET_DATA_HI;
					end
					GET_DATA_HI: begin
						if (bit_cnt == 4'd8) begin
							hi_byte       <= shreg;
							sda_drive_low <= 1'b1;
							state         <= DATA_HI_ACK;
						end
					end
					DATA_HI_ACK: begin
						sda_drive_low <= 1'b0;
						bit_cnt       <= '0;
						state         <= GET_DATA_LO;
					end
					GET_DATA_LO: begin
						if (bit_cnt == 4'd8) begin
							sda_drive_low <= 1'b1;
							state         <= DATA_LO_ACK;
						end
					end
					DATA_LO_ACK: begin
						// low byte is still in shreg, word is complete
						sda_drive_low <= 1'b0;
						bit_cnt       <= '0;
						state         <= GET_DATA_HI;
						req           <= '{we: 1'b1, addr: ptr, wdata: {hi_byte, shreg}};
						req_valid     <= 1'b1;
					end
					SEND_HI, SEND_LO: begin
						if (bit_cnt != 4'd0)
							tx <= {tx[DATA_W-2:0], 1'b0};
						if (bit_cnt == 4'd8) begin
							sda_drive_low <= 1'b0; // master drives the ack
							state         <= (state == SEND_HI) ? HI_GET_ACK : LO_GET_ACK;
						end else if (bit_cnt != 4'd0) begin
							sda_drive_low <= ~tx[DATA_W-2];
						end
					end
					HI_GET_ACK: begin
						if (master_ack) begin
							state         <= SEND_LO;
							bit_cnt       <= '0;
							sda_drive_low <= ~tx[DATA_W-1];
						end else begin
							state <= IGNORE;
						end
					end
					LO_GET_ACK: begin
						if (master_ack) begin
							ptr       <= ptr + 8'd1;
							req       <= '{we: 1'b0, addr: ptr + 8'd1, wdata: '0};
							req_valid <= 1'b1;
							bit_cnt   <= '0;
							state     <= SEND_HI;
						end else begin
							state <= IGNORE; // nack ends the read
						end
					end
					default: ; // idle and ignore wait for start or stop
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/local_port.sv
`timescale 1ns/10ps
`default_nettype none

module local_port
	import i2c_sram_pkg::*;
#(
	parameter int ADDR_W = 8
) (
	input  logic      scl,
	input  logic      rst_n,
	input  mem_req_t  loc_req,
	input  logic      loc_valid,
	output logic      loc_gnt,
	output mem_word_t loc_rdata,
	output logic      loc_rvalid,
	output mem_req_t  arb_req,
	output logic      arb_valid,
	input  logic      arb_gnt,
	input  mem_word_t arb_rdata,
	input  logic      arb_rvalid
);

	localparam logic [7:0] ADDR_MASK = 8'((1 << ADDR_W) - 1);

	mem_req_t pend;    // request waiting for the arbiter
	logic     busy;

	always_ff @(posedge scl) begin
		if (!rst_n) begin
			busy <= 1'b0;
		end else begin
			if (!busy && loc_valid)
				busy <= 1'b1;
			else if (arb_gnt)
				busy <= 1'b0; // valid drops the cycle after the grant
		end
	end

	always_ff @(posedge scl) begin
		if (!busy && loc_valid) begin
			pend      <= loc_req;
			pend.addr <= loc_req.addr & ADDR_MASK;
		end
	end

	assign arb_req    = pend;
	assign arb_valid  = busy;
	assign loc_gnt    = arb_gnt & busy;
	assign loc_rvalid = arb_rvalid; // owner of the read is tracked by the arbiter
	assign loc_rdata  = arb_rdata;

endmodule

`default_nettype wire

//--- logic/sram_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module sram_arbiter
	import i2c_sram_pkg::*;
#(
	parameter int ADDR_W = 8
) (
	input  logic      scl,
	input  logic      rst_n,
	input  mem_req_t  bus_req,
	input  logic      bus_valid,
	output logic      bus_gnt,
	input  mem_req_t  loc_req,
	input  logic      loc_valid,
	output logic      loc_gnt,
	output mem_req_t  mem_req,
	output logic      mem_en,
	input  mem_word_t mem_rdata,
	output mem_word_t rdata,
	output logic      bus_rvalid,
	output logic      loc_rvalid
);

	localparam logic [7:0] ADDR_MASK = 8'((1 << ADDR_W) - 1);

	mem_req_t sel_req;

	// fixed priority, the i2c side never waits
	assign bus_gnt = bus_valid;
	assign loc_gnt = loc_valid & ~bus_valid;
	assign mem_en  = bus_valid | loc_valid;
	assign sel_req = bus_valid ? bus_req : loc_req;

	always_comb begin
		mem_req      = sel_req;
		mem_req.addr = sel_req.addr & ADDR_MASK;
	end

	// owner of the read in flight, data comes back one cycle later
	always_ff @(posedge scl) begin
		if (!rst_n) begin
			bus_rvalid <= 1'b0;
			loc_rvalid <= 1'b0;
		end else begin
			bus_rvalid <= bus_gnt & ~bus_req.we;
			loc_rvalid <= loc_gnt & ~loc_req.we;
		end
	end

	assign rdata = mem_rdata; // shared, rvalid tells who owns it

endmodule

`default_nettype wire

//--- logic/sram_array.sv
`timescale 1ns/10ps
`default_nettype none

module sram_array
	import i2c_sram_pkg::*;
#(
	parameter int ADDR_W = 8
) (
	input  logic      scl,
	input  logic      en,
	input  mem_req_t  req,
	output mem_word_t rdata
);

	mem_word_t mem [2**ADDR_W];

	always_ff @(posedge scl) begin
		if (en) begin
			if (req.we)
				mem[req.addr[ADDR_W-1:0]] <= req.wdata;
			else
				rdata <= mem[req.addr[ADDR_W-1:0]]; // one cycle read
		end
	end

endmodule

`default_nettype wire

//--- logic/i2c_sram_top.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_sram_top
	import i2c_sram_pkg::*;
#(
	parameter int ADDR_W = 8
) (
	input  logic      scl,
	input  logic      rst_n,
	input  logic      bus_scl,
	input  logic      bus_sda,
	input  dev_addr_t dev_addr,
	output logic      sda_oe,     // high pulls sda low
	input  mem_req_t  loc_req,
	input  logic      loc_valid,
	output logic      loc_gnt,
	output mem_word_t loc_rdata,
	output logic      loc_rvalid
);

	bus_event_t evt;
	logic       sda_drive_low;
	mem_req_t   bus_req;
	logic       bus_req_valid;
	logic       bus_gnt;
	logic       bus_rvalid;
	mem_req_t   lp_req;      // local port to arbiter
	logic       lp_valid;
	logic       lp_gnt;
	logic       lp_rvalid;
	mem_word_t  arb_rdata;
	mem_req_t   mem_req;
	logic       mem_en;
	mem_word_t  mem_rdata;

	i2c_line_sync u_line_sync (
		.scl     (scl),
		.rst_n   (rst_n),
		.bus_scl (bus_scl),
		.bus_sda (bus_sda),
		.evt     (evt)
	);

	i2c_target_fsm u_target (
		.scl           (scl),
		.rst_n         (rst_n),
		.evt           (evt),
		.dev_addr      (dev_addr),
		.sda_drive_low (sda_drive_low),
		.req           (bus_req),
		.req_valid     (bus_req_valid),
		.gnt           (bus_gnt),
		.rdata         (arb_rdata),
		.rvalid        (bus_rvalid)
	);

	local_port #(
		.ADDR_W (ADDR_W)
	) u_local (
		.scl        (scl),
		.rst_n      (rst_n),
		.loc_req    (loc_req),
		.loc_valid  (loc_valid),
		.loc_gnt    (loc_gnt),
		.loc_rdata  (loc_rdata),
		.loc_rvalid (loc_rvalid),
		.arb_req    (lp_req),
		.arb_valid  (lp_valid),
		.arb_gnt    (lp_gnt),
		.arb_rdata  (arb_rdata),
		.arb_rvalid (lp_rvalid)
	);

	sram_arbiter #(
		.ADDR_W (ADDR_W)
	) u_arbiter (
		.scl        (scl),
		.rst_n      (rst_n),
		.bus_req    (bus_req),
		.bus_valid  (bus_req_valid),
		.bus_gnt    (bus_gnt),
		.loc_req    (lp_req),
		.loc_valid  (lp_valid),
		.loc_gnt    (lp_gnt),
		.mem_req    (mem_req),
		.mem_en     (mem_en),
		.mem_rdata  (mem_rdata),
		.rdata      (arb_rdata),
		.bus_rvalid (bus_rvalid),
		.loc_rvalid (lp_rvalid)
	);

	sram_array #(
		.ADDR_W (ADDR_W)
	) u_sram (
		.scl   (scl),
		.en    (mem_en),
		.req   (mem_req),
		.rdata (mem_rdata)
	);

	assign sda_oe = sda_drive_low; // open drain, target never drives high

endmodule

`default_nettype wire

//--- dv/i2c_sram_tb.sv
`timescale 1ns/10ps
`default_nettype none

module i2c_sram_tb
	import i2c_sram_pkg::*;
();

	localparam dev_addr_t DEV_ADDR = 7'h50;
	// bus bits per test, a byte is 9 bits, start and stop one bit each
	localparam int TEST_BITS    = 56 + 85 + 38 + 92 + 67 + 20 * 49;
	localparam int LIMIT_CYCLES = 2 * TEST_BITS * 16;

	logic        scl;
	logic        rst_n;
	logic        scl_m;      // master drive of the bus clock
	logic        sda_m;      // master drive of sda, 1 releases the line
	logic        sda_bus;
	dev_addr_t   dev_addr;
	logic        sda_oe;
	mem_req_t    loc_req;
	logic        loc_valid;
	logic        loc_gnt;
	mem_word_t   loc_rdata;
	logic        loc_rvalid;
	mem_word_t   ref_mem [256];
	mem_word_t   gnt_ref;      // model word when the last local read was granted
	mem_word_t   wr_words [8]; // words for the next bus write
	mem_word_t   rd_words [8];
	int          errors;
	int          checks;
	int          tests_run;
	int          cycle_cnt = 0;
	int unsigned seed_ret;

	assign sda_bus = sda_m & ~sda_oe; // wired-and of both drivers

	i2c_sram_top #(
		.ADDR_W (8)
	) dut0 (
		.scl        (scl),
		.rst_n      (rst_n),
		.bus_scl    (scl_m),
		.bus_sda    (sda_bus),
		.dev_addr   (dev_addr),
		.sda_oe     (sda_oe),
		.loc_req    (loc_req),
		.loc_valid  (loc_valid),
		.loc_gnt    (loc_gnt),
		.loc_rdata  (loc_rdata),
		.loc_rvalid (loc_rvalid)
	);

	always #50 scl = ~scl;

	always @(posedge scl) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= LIMIT_CYCLES) begin
			$display("timeout, the tests did not end within %0d cycles", LIMIT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge scl);
	endtask

	// 16 cycles, sda moves while scl is low and is sampled mid high phase
	task automatic clock_bit(input logic b, output logic sampled);
		sda_m <= b;
		wait_cycles(4);
		scl_m <= 1'b1;
		wait_cycles(4);
		@(negedge scl);
		sampled = sda_bus;
		wait_cycles(4);
		scl_m <= 1'b0;
		wait_cycles(4);
	endtask

	task automatic i2c_start();
		sda_m <= 1'b1;
		wait_cycles(4);
		scl_m <= 1'b1;
		wait_cycles(4);
		sda_m <= 1'b0; // sda falls with scl high
		wait_cycles(4);
		scl_m <= 1'b0;
		wait_cycles(4);
	endtask

	task automatic i2c_stop();
		sda_m <= 1'b0;
		wait_cycles(4);
		scl_m <= 1'b1;
		wait_cycles(4);
		sda_m <= 1'b1;
		wait_cycles(8);
	endtask

	task automatic i2c_write_byte(input logic [7:0] b, output logic ack);
		logic s;
		for (int i = 7; i >= 0; i--)
			clock_bit(b[i], s);
		clock_bit(1'b1, s); // released, target pulls low to ack
		ack = ~s;
	endtask

	task automatic i2c_read_byte(input logic ack, output logic [7:0] b);
		logic s;
		for (int i = 7; i >= 0; i--) begin
			clock_bit(1'b1, s);
			b[i] = s;
		end
		clock_bit(~ack, s);
	endtask

	task automatic loc_write(input logic [7:0] a, input mem_word_t d);
		loc_req   <= '{we: 1'b1, addr: a, wdata: d};
		loc_valid <= 1'b1;
		@(posedge scl);
		loc_valid <= 1'b0; // port has latched the request
		do @(negedge scl); while (!loc_gnt);
		@(posedge scl);
		ref_mem[a] = d;
	endtask

	task automatic loc_read(input logic [7:0] a, output mem_word_t d);
		loc_req   <= '{we: 1'b0, addr: a, wdata: '0};
		loc_valid <= 1'b1;
		@(posedge scl);
		loc_valid <= 1'b0;
		do @(negedge scl); while (!loc_gnt);
		gnt_ref = ref_mem[a]; // sram is read at the end of this cycle
		do @(negedge scl); while (!loc_rvalid);
		d = loc_rdata;
		@(posedge scl);
	endtask

	task automatic check_word(input string name, input mem_word_t got, input mem_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_ack(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	task automatic bus_write_burst(input logic [7:0] ptr, input int n);
		logic       ack;
		logic [7:0] a;
		a = ptr;
		i2c_start();
		i2c_write_byte({DEV_ADDR, MODE_WRITE}, ack);
		check_ack("bus_sda ack of device address", ack, 1'b1);
		i2c_write_byte(ptr, ack);
		check_ack("bus_sda ack of pointer", ack, 1'b1);
		for (int i = 0; i < n; i++) begin
			i2c_write_byte(wr_words[i][15:8], ack);
			check_ack("bus_sda ack of high byte", ack, 1'b1);
			i2c_write_byte(wr_words[i][7:0], ack);
			check_ack("bus_sda ack of low byte", ack, 1'b1);
			ref_mem[a] = wr_words[i];
			a++; // pointer moves on after every word
		end
		i2c_stop();
	endtask

	task automatic bus_read_burst(input logic [7:0] ptr, input int n);
		logic       ack;
		logic [7:0] hi;
		logic [7:0] lo;
		i2c_start();
		i2c_write_byte({DEV_ADDR, MODE_WRITE}, ack);
		check_ack("bus_sda ack of device address", ack, 1'b1);
		i2c_write_byte(ptr, ack);
		check_ack("bus_sda ack of pointer", ack, 1'b1);
		i2c_stop();
		i2c_start();
		i2c_write_byte({DEV_ADDR, MODE_READ}, ack);
		check_ack("bus_sda ack of read address", ack, 1'b1);
		for (int i = 0; i < n; i++) begin
			i2c_read_byte(1'b1, hi);
			i2c_read_byte(i < n - 1, lo); // nack after the last word
			rd_words[i] = {hi, lo};
		end
		i2c_stop();
	endtask

	task automatic finish_test(input string name, input int err0);
		tests_run++;
		if (errors == err0)
			$display("test %0d, %s: ok", tests_run, name);
		else
			$display("test %0d, %s: %0d errors", tests_run, name, errors - err0);
	endtask

	task automatic test_bus_write();
		int        err0;
		mem_word_t d;
		err0        = errors;
		wr_words[0] = 16'hA55A;
		wr_words[1] = 16'h1234;
		bus_write_burst(8'h10, 2);
		loc_read(8'h10, d);
		check_word("loc_rdata at 10h", d, ref_mem[8'h10]);
		loc_read(8'h11, d);
		check_word("loc_rdata at 11h", d, ref_mem[8'h11]);
		finish_test("bus write burst", err0);
	endtask

	task automatic test_bus_read();
		int err0;
		err0 = errors;
		loc_write(8'h20, 16'hBEEF);
		loc_write(8'h21, 16'h0F0F);
		loc_write(8'h22, 16'h8001);
		bus_read_burst(8'h20, 3);
		for (int i = 0; i < 3; i++)
			check_word("bus_sda read word", rd_words[i], ref_mem[8'h20 + i]);
		finish_test("bus read with auto increment", err0);
	endtask

	task automatic test_wrong_address();
		int        err0;
		logic      ack;
		mem_word_t d;
		err0 = errors;
		i2c_start();
		i2c_write_byte({DEV_ADDR ^ 7'h01, MODE_WRITE}, ack);
		check_ack("bus_sda ack of foreign address", ack, 1'b0);
		i2c_write_byte(8'h10, ack);
		check_ack("bus_sda ack while ignored", ack, 1'b0);
		i2c_write_byte(8'hDE, ack);
		i2c_write_byte(8'hAD, ack);
		i2c_stop();
		loc_read(8'h10, d);
		check_word("loc_rdata at 10h", d, ref_mem[8'h10]);
		finish_test("wrong device address", err0);
	endtask

	task automatic test_concurrent_reads();
		int        err0;
		logic      burst_done;
		logic [1:0] idx;
		mem_word_t d;
		mem_word_t old_val [4];
		err0 = errors;
		for (int k = 0; k < 4; k++) begin
			old_val[k]  = 16'h0A00 + 16'(k);
			wr_words[k] = 16'hC0D0 + 16'(k);
			loc_write(8'h40 + 8'(k), old_val[k]);
		end
		burst_done = 1'b0;
		idx        = '0;
		fork
			begin
				bus_write_burst(8'h40, 4);
				burst_done = 1'b1;
			end
			while (!burst_done) begin
				loc_read(8'h40 + {6'b0, idx}, d);
				check_word("loc_rdata during bus burst", d, gnt_ref);
				idx++;
			end
		join
		for (int k = 0; k < 4; k++) begin
			loc_read(8'h40 + 8'(k), d);
			check_word("loc_rdata after bus burst", d, ref_mem[8'h40 + k]);
		end
		finish_test("local reads during bus write", err0);
	endtask

	task automatic test_stop_mid_word();
		int        err0;
		logic      ack;
		mem_word_t d;
		err0 = errors;
		loc_write(8'h30, 16'h3030);
		loc_write(8'h31, 16'h3131);
		i2c_start();
		i2c_write_byte({DEV_ADDR, MODE_WRITE}, ack);
		i2c_write_byte(8'h30, ack);
		i2c_write_byte(8'hEE, ack);
		check_ack("bus_sda ack of lone high byte", ack, 1'b1);
		i2c_stop();
		loc_read(8'h30, d);
		check_word("loc_rdata at 30h", d, ref_mem[8'h30]);
		wr_words[0] = 16'h5AA5;
		bus_write_burst(8'h31, 1);
		loc_read(8'h31, d);
		check_word("loc_rdata at 31h", d, ref_mem[8'h31]);
		finish_test("stop after high byte", err0);
	endtask

	task automatic test_random_cross_port();
		int          err0;
		logic [31:0] r;
		logic [7:0]  a;
		mem_word_t   w;
		mem_word_t   d;
		err0 = errors;
		for (int n = 0; n < 20; n++) begin
			r = $urandom;
			a = r[7:0];
			r = $urandom;
			w = r[15:0];
			if (r[16]) begin
				wr_words[0] = w;
				bus_write_burst(a, 1);
				loc_read(a, d);
				check_word("loc_rdata after bus write", d, ref_mem[a]);
			end else begin
				loc_write(a, w);
				bus_read_burst(a, 1);
				check_word("bus_sda read word", rd_words[0], ref_mem[a]);
			end
		end
		finish_test("random words across ports", err0);
	endtask

	initial begin
		scl       = 1'b0;
		rst_n     = 1'b0;
		scl_m     = 1'b1; // idle bus
		sda_m     = 1'b1;
		dev_addr  = DEV_ADDR;
		loc_req   = '0;
		loc_valid = 1'b0;
		errors    = 0;
		checks    = 0;
		tests_run = 0;
		seed_ret  = $urandom(32'h15f88e43);
		wait_cycles(2);
		rst_n <= 1'b1;
		wait_cycles(4);
		test_bus_write();
		test_bus_read();
		test_wrong_address();
		test_concurrent_reads();
		test_stop_mid_word();
		test_random_cross_port();
		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
logic/i2c_sram_pkg.sv
logic/i2c_line_sync.sv
logic/i2c_target_fsm.sv
logic/local_port.sv
logic/sram_arbiter.sv
logic/sram_array.sv
logic/i2c_sram_top.sv
dv/i2c_sram_tb.sv

//--- Bender.yml
package:
  name: i2c_sram

sources:
  - logic/i2c_sram_pkg.sv
  - logic/i2c_line_sync.sv
  - logic/i2c_target_fsm.sv
  - logic/local_port.sv
  - logic/sram_arbiter.sv
  - logic/sram_array.sv
  - logic/i2c_sram_top.sv
  - target: test
    files:
      - dv/i2c_sram_tb.sv
